/* list.f */
hw/core_pkg.sv
hw/core_fetch_unit.sv
hw/core_fetch_buffer.sv
hw/core_instr_align.sv
hw/core_fetch_top.sv
tb/core_fetch_top_sva.sv
tb/tb_core_fetch_top.sv

/* tb/tb_core_fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none
// ------------------------------
// Front end testbench
// Memory model with random grant latency, expected instruction
// stream from the length rule, directed tests
// ------------------------------
module tb_core_fetch_top;

    localparam int          WAIT_LIMIT = 100;                         // Cycles per wait
    localparam logic [31:0] BASE       = core_pkg::PC_RESET_ADDRESS;
    localparam logic [31:0] ERR_ADDR   = BASE + 32'h18;               // Erroring word

    logic                g_clk;
    logic                rst_n;
    core_pkg::cf_req_t   cf;
    logic                cf_ack;
    core_pkg::imem_req_t imem;
    core_pkg::imem_rsp_t imem_rsp;
    logic                issue_ready;
    core_pkg::issue_t    issue;

    logic [31:0] mem [64];        // Words from BASE
    integer      seed;            // $random state
    logic [31:0] rnd;             // Draw of this cycle
    int          lat_left;        // Cycles until next grant
    logic        ready_mode;      // Random issue_ready when set
    logic        err_en;          // Error on ERR_ADDR when set

    core_fetch_top u_core_fetch_top (
        .g_clk       (g_clk),
        .rst_n       (rst_n),
        .cf          (cf),
        .cf_ack      (cf_ack),
        .imem        (imem),
        .imem_rsp    (imem_rsp),
        .issue_ready (issue_ready),
        .issue       (issue)
    );

    bind core_fetch_top core_fetch_top_sva u_sva (
        .g_clk       (g_clk),
        .rst_n       (rst_n),
        .cf          (cf),
        .cf_ack      (cf_ack),
        .imem        (imem),
        .imem_rsp    (imem_rsp),
        .issue_ready (issue_ready),
        .issue       (issue),
        .count       (count)
    );

    always #4 g_clk = ~g_clk;                                       // 8 ns period

    // Watch the bound checker
    always @(negedge g_clk) begin
        if (u_core_fetch_top.u_sva.fail_cnt != 0) begin
            $display("A protocol assertion in the bound checker failed");
            $display("*** FAILED ***");
            $fatal(1);
        end
    end

    // ------------------------------
    // Memory model and ready driver
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - BASE;
        return mem[off[7:2]];                                       // Wraps at 64 words
    endfunction

    function automatic logic [15:0] mem_hw(input logic [31:0] addr);
        logic [31:0] w;
        w = mem_word(addr);
        return addr[1] ? w[31:16] : w[15:0];
    endfunction

    function automatic logic word_err(input logic [31:0] addr);
        return err_en && (addr[31:2] == ERR_ADDR[31:2]);
    endfunction

    always @(posedge g_clk) begin
        #1;
        rnd         = $random(seed);
        issue_ready = ready_mode ? rnd[4] : 1'b1;
        imem_rsp    = '0;
        if (imem.req === 1'b1) begin
            if (lat_left == 0) begin
                imem_rsp.gnt   = 1'b1;
                imem_rsp.rdata = mem_word(imem.addr);
                imem_rsp.err   = err_en && (imem.addr == ERR_ADDR);
                lat_left       = int'(rnd[1:0]);                    // 0..3 for the next one
            end else begin
                lat_left = lat_left - 1;
            end
        end
    end

    task automatic fill_memory();
        logic [31:0] w;
        for (int i = 0; i < 64; i++) begin
            w        = $random(seed);
            w[1:0]   = w[2] ? 2'b11 : {1'b0, w[3]};                 // 32-bit or RVC start
            w[17:16] = w[18] ? 2'b11 : {1'b0, w[19]};
            mem[i]   = w;
        end
    endtask

    // ------------------------------
    // Checks and waits
    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s: expected %h, actual %h", what, exp, act);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout in %s", what);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic apply_reset(input logic rand_ready, input logic err_on);
        @(negedge g_clk);
        ready_mode = rand_ready;                                    // Away from driver edge
        err_en     = err_on;
        @(posedge g_clk);
        #1;
        rst_n = 1'b0;
        cf    = '0;
        repeat (3) @(posedge g_clk);
        #1;
        rst_n = 1'b1;
    endtask

    // Returns at the negedge before a transfer edge
    task automatic wait_transfer(input string test);
        int cycles;
        cycles = 0;
        @(negedge g_clk);
        while (!(issue.valid && issue_ready) && cycles < WAIT_LIMIT) begin
            cycles++;
            @(negedge g_clk);
        end
        if (!(issue.valid && issue_ready)) report_timeout({test, ", no instruction was issued"});
    endtask

    task automatic expect_stream(input string test, input logic [31:0] start_pc, input int n);
        logic [31:0] pc;
        logic [15:0] lo;
        logic [31:0] instr;
        logic        is32;
        logic        ferr;
        pc = start_pc;
        repeat (n) begin
            lo    = mem_hw(pc);
            is32  = lo[1:0] == 2'b11;                               // Length rule
            instr = is32 ? {mem_hw(pc + 32'd2), lo} : {16'h0000, lo};
            ferr  = word_err(pc) || (is32 && word_err(pc + 32'd2));
            wait_transfer(test);
            check_value({test, " pc"}, pc, issue.pc);
            check_value({test, " instr"}, instr, issue.instr);
            check_value({test, " i16bit"}, 32'(!is32), 32'(issue.i16bit));
            check_value({test, " ferr"}, 32'(ferr), 32'(issue.ferr));
            pc = pc + (is32 ? 32'd4 : 32'd2);
        end
    endtask

    task automatic redirect_to(input string test, input logic [31:0] target);
        int cycles;
        @(posedge g_clk);
        #1;
        cf.valid  = 1'b1;
        cf.target = target;
        cycles    = 0;
        @(negedge g_clk);
        while (!cf_ack && cycles < WAIT_LIMIT) begin
            cycles++;
            @(negedge g_clk);
        end
        if (!cf_ack) report_timeout({test, ", the redirect was never acknowledged"});
        @(posedge g_clk);                                           // Ack edge
        #1;
        cf.valid = 1'b0;
    endtask

    // ------------------------------
    // Directed tests
    task automatic reset_state();
        int cycles;
        apply_reset(1'b0, 1'b0);
        @(negedge g_clk);
        check_value("reset issue.valid", 32'd0, 32'(issue.valid));
        check_value("reset cf_ack", 32'd0, 32'(cf_ack));
        cycles = 0;
        while (imem.req !== 1'b1 && cycles < WAIT_LIMIT) begin
            cycles++;
            @(negedge g_clk);
        end
        if (imem.req !== 1'b1) report_timeout("reset, fetch never requested a word");
        check_value("reset imem.addr", BASE, imem.addr);
    endtask

    task automatic sequential_issue();
        expect_stream("sequential", BASE, 30);                      // Continues from reset
    endtask

    task automatic back_pressure();
        apply_reset(1'b1, 1'b0);
        expect_stream("back-pressure", BASE, 30);
        @(negedge g_clk);
        ready_mode = 1'b0;
    endtask

    task automatic control_flow_change();
        redirect_to("redirect word", BASE + 32'h40);
        expect_stream("redirect word", BASE + 32'h40, 12);
        redirect_to("redirect half", BASE + 32'h22);               // Upper halfword start
        expect_stream("redirect half", BASE + 32'h22, 12);
    endtask

    task automatic fetch_error();
        apply_reset(1'b0, 1'b1);
        expect_stream("fetch error", BASE, 30);
    endtask

    initial begin
        g_clk       = 1'b0;
        rst_n       = 1'b0;
        cf          = '0;
        imem_rsp    = '0;
        issue_ready = 1'b0;
        ready_mode  = 1'b0;
        err_en      = 1'b0;
        lat_left    = 0;
        seed        = 32'h042e_0f8f;
        fill_memory();
        reset_state();
        sequential_issue();
        back_pressure();
        control_flow_change();
        fetch_error();
        if (u_core_fetch_top.u_sva.fail_cnt == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("*** FAILED ***");
            $fatal(1);
        end
    end

endmodule
`default_nettype wire

/* tb/core_fetch_top_sva.sv */
`timescale 1ns/1ps
`default_nettype none
// ------------------------------
// Front end protocol checks
// Memory bus, redirect and issue handshakes, buffer occupancy
// ------------------------------
module core_fetch_top_sva (
    input  logic                            g_clk,        // Clock
    input  logic                            rst_n,        // Sync reset, active low
    input  core_pkg::cf_req_t               cf,           // Redirect request
    input  logic                            cf_ack,       // Redirect taken
    input  core_pkg::imem_req_t             imem,         // Memory request
    input  core_pkg::imem_rsp_t             imem_rsp,     // Memory response
    input  logic                            issue_ready,  // Decode accepts
    input  core_pkg::issue_t                issue,        // Issued instruction
    input  logic [core_pkg::FBUF_CNT_W-1:0] count         // Buffer occupancy
);

    int fail_cnt = 0;                                     // Assertion failures so far

    // ------------------------------
    // Handshake stability
    a_addr_stable : assert property (@(posedge g_clk) disable iff (!rst_n)
        (imem.req && !imem_rsp.gnt) |=> (imem.req && $stable(imem.addr)))
        else begin
            $error("imem.addr moved before the grant");
            fail_cnt++;
        end

    a_target_stable : assert property (@(posedge g_clk) disable iff (!rst_n)
        (cf.valid && !cf_ack) |=> (cf.valid && $stable(cf.target)))
        else begin
            $error("cf.target moved before cf_ack");
            fail_cnt++;
        end

    // A redirect may drop a stalled instruction
    a_issue_stable : assert property (@(posedge g_clk) disable iff (!rst_n)
        (issue.valid && !issue_ready && !cf_ack) |=> $stable(issue))
        else begin
            $error("issue changed under back-pressure");
            fail_cnt++;
        end

    // ------------------------------
    // Occupancy bound
    a_count_max : assert property (@(posedge g_clk) disable iff (!rst_n)
        count <= core_pkg::FBUF_DEPTH)
        else begin
            $error("fetch buffer count above its depth");
            fail_cnt++;
        end

endmodule
`default_nettype wire

/* hw/core_fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none
// ------------------------------
// Core front end
// Fetch unit, fetch buffer and instruction align
// ------------------------------
module core_fetch_top (
    input  logic                g_clk,        // Clock
    input  logic                rst_n,        // Sync reset, active low
    input  core_pkg::cf_req_t   cf,           // Control flow change request
    output logic                cf_ack,       // Redirect taken
    output core_pkg::imem_req_t imem,         // Instruction memory request
    input  core_pkg::imem_rsp_t imem_rsp,     // Instruction memory response
    input  logic                issue_ready,  // Decode accepts
    output core_pkg::issue_t    issue         // Issued instruction
);

    // ------------------------------
    // Inner wiring
    core_pkg::fetch_push_t           push;    // Fetch to buffer
    core_pkg::fetch_hw_t [1:0]       head;    // Buffer to align
    logic [core_pkg::FBUF_CNT_W-1:0] count;   // Buffer occupancy
    logic                            eat_2;   // Align retires one halfword
    logic                            eat_4;   // Align retires two halfwords

    // ------------------------------
    // Producer
    core_fetch_unit u_fetch_unit (
        .g_clk    (g_clk),
        .rst_n    (rst_n),
        .cf       (cf),
        .cf_ack   (cf_ack),
        .imem     (imem),
        .imem_rsp (imem_rsp),
        .count    (count),
        .push     (push)
    );

    // Buffer, flushed by the ack pulse
    core_fetch_buffer u_fetch_buffer (
        .g_clk (g_clk),
        .rst_n (rst_n),
        .flush (cf_ack),
        .push  (push),
        .eat_2 (eat_2),
        .eat_4 (eat_4),
        .head  (head),
        .count (count)
    );

    // Consumer, decode intake
    core_instr_align u_instr_align (
        .g_clk       (g_clk),
        .rst_n       (rst_n),
        .flush       (cf_ack),
        .cf_target   (cf.target),
        .head        (head),
        .count       (count),
        .issue_ready (issue_ready),
        .eat_2       (eat_2),
        .eat_4       (eat_4),
        .issue       (issue)
    );

endmodule
`default_nettype wire

/* hw/core_instr_align.sv */
`timescale 1ns/1ps
`default_nettype none
// ------------------------------
// Instruction align
// Finds 16 or 32-bit instructions at the buffer head, loads the
// issue register and tracks the issue PC
// ------------------------------
module core_instr_align (
    input  logic                            g_clk,        // Clock
    input  logic                            rst_n,        // Sync reset, active low
    input  logic                            flush,        // Redirect acknowledged
    input  logic [core_pkg::XLEN-1:0]       cf_target,    // Redirect PC
    input  core_pkg::fetch_hw_t [1:0]       head,         // Oldest two halfwords
    input  logic [core_pkg::FBUF_CNT_W-1:0] count,        // Buffer occupancy
    input  logic                            issue_ready,  // Decode accepts
    output logic                            eat_2,        // Took a 16-bit instr
    output logic                            eat_4,        // Took a 32-bit instr
    output core_pkg::issue_t                issue         // Issued instruction
);

    // ------------------------------
    // Length detect
    logic                      is32;        // Head starts a 32-bit instr
    logic                      complete;    // All its halfwords buffered
    logic                      load;        // Issue register loads
    logic [core_pkg::XLEN-1:0] pc_q;        // PC of instruction at head
    logic [core_pkg::XLEN-1:0] pc_step;     // Head PC plus length

    logic                      vld_q;       // Issue register full
    logic [31:0]               instr_q;     // Issued instruction word
    logic [core_pkg::XLEN-1:0] ipc_q;       // Issued PC
    logic                      i16_q;       // Issued is compressed
    logic                      ferr_q;      // Issued had a fetch error

    assign is32 = head[0].data[1:0] == 2'b11;   // RVC uses 00, 01, 10

    always_comb begin
        if (is32) begin
            complete = count >= 2'd2;
        end else begin
            complete = count >= 2'd1;
        end
    end

    // Free register or one being taken this edge
    assign load  = complete && (!vld_q || issue_ready);
    assign eat_2 = load && !is32;
    assign eat_4 = load && is32;

    assign pc_step = pc_q + (is32 ? 3'd4 : 3'd2);

    // ------------------------------
    // Control state
    always_ff @(posedge g_clk) begin
        if (!rst_n) begin
            vld_q <= 1'b0;
            pc_q  <= core_pkg::PC_RESET_ADDRESS;
        end else if (flush) begin
            vld_q <= 1'b0;                      // Drop instruction in flight
            pc_q  <= cf_target;                 // Restart at target
        end else if (load) begin
            vld_q <= 1'b1;
            pc_q  <= pc_step;
        end else if (issue_ready) begin
            vld_q <= 1'b0;                      // Taken, nothing to replace it
        end
    end

    // ------------------------------
    // Issue payload
    always_ff @(posedge g_clk) begin
        if (load) begin
            instr_q <= is32 ? {head[1].data, head[0].data} : {16'h0000, head[0].data};
            ipc_q   <= pc_q;
            i16_q   <= !is32;
            ferr_q  <= head[0].err || (is32 && head[1].err); // Any part errored
        end
    end

    assign issue = '{valid:  vld_q,
                     instr:  instr_q,
                     pc:     ipc_q,
                     i16bit: i16_q,
                     ferr:   ferr_q};

endmodule
`default_nettype wire

/* hw/core_fetch_buffer.sv */
`timescale 1ns/1ps
`default_nettype none
// ------------------------------
// Fetch buffer
// Circular halfword FIFO, up to two pushes and two pops a cycle,
// flushed on a redirect
// ------------------------------
module core_fetch_buffer (
    input  logic                            g_clk,    // Clock
    input  logic                            rst_n,    // Sync reset, active low
    input  logic                            flush,    // Drop all entries
    input  core_pkg::fetch_push_t           push,     // From fetch
    input  logic                            eat_2,    // Retire one halfword
    input  logic                            eat_4,    // Retire two halfwords
    output core_pkg::fetch_hw_t [1:0]       head,     // head[0] is the oldest
    output logic [core_pkg::FBUF_CNT_W-1:0] count     // Occupancy
);

    // ------------------------------
    // Storage and pointers
    core_pkg::fetch_hw_t mem [core_pkg::FBUF_DEPTH]; // Halfword slots

    logic [core_pkg::FBUF_PTR_W-1:0] wr_ptr;        // Next free slot
    logic [core_pkg::FBUF_PTR_W-1:0] rd_ptr;        // Oldest entry
    logic [core_pkg::FBUF_PTR_W-1:0] wr_ptr_1;      // Slot after wr_ptr
    logic [core_pkg::FBUF_PTR_W-1:0] rd_ptr_1;      // Entry after rd_ptr
    logic [1:0]                      pop_cnt;       // Halfwords retired

    // Depth is a power of two, pointers wrap by themselves
    assign wr_ptr_1 = wr_ptr + 1'b1;
    assign rd_ptr_1 = rd_ptr + 1'b1;

    always_comb begin
        if (eat_4) begin
            pop_cnt = 2'd2;
        end else if (eat_2) begin
            pop_cnt = 2'd1;
        end else begin
            pop_cnt = 2'd0;
        end
    end

    // ------------------------------
    // Write side
    always_ff @(posedge g_clk) begin
        if (push.cnt != 2'd0) begin
            mem[wr_ptr] <= push.hw[0];              // Lower address first
        end
        if (push.cnt == 2'd2) begin
            mem[wr_ptr_1] <= push.hw[1];
        end
    end

    // ------------------------------
    // Read side
    // Slots past count hold stale data, align checks count
    assign head[0] = mem[rd_ptr];
    assign head[1] = mem[rd_ptr_1];

    // ------------------------------
    // Pointers and occupancy
    always_ff @(posedge g_clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;                           // Flush wins over push and pop
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + push.cnt;
            rd_ptr <= rd_ptr + pop_cnt;
            count  <= count + push.cnt - pop_cnt;   // Net change this edge
        end
    end

endmodule
`default_nettype wire

/* hw/core_fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none
// ------------------------------
// Fetch unit
// Keeps the fetch word address, runs requests on the instruction
// bus, acknowledges redirects and pushes halfwords to the buffer
// ------------------------------
module core_fetch_unit (
    input  logic                            g_clk,     // Clock
    input  logic                            rst_n,     // Sync reset, active low
    input  core_pkg::cf_req_t               cf,        // Control flow change request
    output logic                            cf_ack,    // Redirect taken this cycle
    output core_pkg::imem_req_t             imem,      // Instruction memory request
    input  core_pkg::imem_rsp_t             imem_rsp,  // Instruction memory response
    input  logic [core_pkg::FBUF_CNT_W-1:0] count,     // Buffer occupancy
    output core_pkg::fetch_push_t           push       // Halfwords into the buffer
);

    // ------------------------------
    // State
    logic [core_pkg::XLEN-1:0]       fetch_addr;   // Word address being fetched
    logic                            req_pend;     // Request out on the bus
    logic                            drop_hw;      // Skip low half of next word

    logic                            gnt;          // Our request granted
    logic                            take;         // Grant kept, not redirected
    logic                            req_next;     // Request in the next cycle
    logic [core_pkg::FBUF_CNT_W-1:0] cnt_bound;    // Occupancy after this edge, no pops
    logic                            room;         // Buffer can take another word

    assign imem.req  = req_pend;                   // Held until a grant
    assign imem.addr = fetch_addr;                 // Only moves on grant or ack

    assign gnt = req_pend && imem_rsp.gnt;

    // Ack when nothing is outstanding, or the outstanding word
    // is granted now and gets dropped
    assign cf_ack = cf.valid && (!req_pend || imem_rsp.gnt);

    assign take = gnt && !cf_ack;

    // ------------------------------
    // Halfword push
    always_comb begin
        push = '0;                                 // Nothing by default
        if (take) begin
            push.cnt          = drop_hw ? 2'd1 : 2'd2;      // Odd target skips one
            push.hw[0].data   = drop_hw ? imem_rsp.rdata[31:16]
                                        : imem_rsp.rdata[15:0];
            push.hw[0].err    = imem_rsp.err;
            push.hw[1].data   = imem_rsp.rdata[31:16];      // Ignored when cnt is 1
            push.hw[1].err    = imem_rsp.err;
        end
    end

    // ------------------------------
    // Request sequencing
    // Pops are ignored here so the bound can only be high,
    // never low, and the buffer cannot overflow
    assign cnt_bound = count + {{(core_pkg::FBUF_CNT_W-2){1'b0}}, push.cnt};
    assign room      = cnt_bound <= core_pkg::FBUF_FILL_MAX;

    always_comb begin
        if (cf_ack) begin
            req_next = 1'b0;                       // Restart after redirect
        end else if (req_pend && !imem_rsp.gnt) begin
            req_next = 1'b1;                       // Hold until granted
        end else if (cf.valid) begin
            req_next = 1'b0;                       // No new word during redirect
        end else begin
            req_next = room;                       // Next word if it fits
        end
    end

    always_ff @(posedge g_clk) begin
        if (!rst_n) begin
            fetch_addr <= core_pkg::PC_RESET_ADDRESS;
            req_pend   <= 1'b0;
            drop_hw    <= 1'b0;
        end else begin
            req_pend <= req_next;
            if (cf_ack) begin
                fetch_addr <= {cf.target[core_pkg::XLEN-1:2], 2'b00}; // Word of target
                drop_hw    <= cf.target[1];        // Upper half start
            end else if (gnt) begin
                fetch_addr <= fetch_addr + 3'd4;   // Next word
                drop_hw    <= 1'b0;
            end
        end
    end

endmodule
`default_nettype wire

/* hw/core_pkg.sv */
`default_nettype none
// ------------------------------
// Core front end package
// Widths, reset PC, fetch buffer sizing and the structs passed
// between fetch, buffer and instruction align
// ------------------------------
package core_pkg;

    // ------------------------------
    // Sizes and constants
    localparam int XLEN       = 32;                    // Data and PC width
    localparam int FBUF_DEPTH = 8;                     // Buffer capacity, halfwords
    localparam int FBUF_CNT_W = 4;                     // Occupancy count width
    localparam int FBUF_PTR_W = 3;                     // Read/write pointer width

    localparam logic [XLEN-1:0] PC_RESET_ADDRESS = 32'h1000_0000; // Word aligned

    // Highest occupancy at which fetch may still ask for a word
    localparam logic [FBUF_CNT_W-1:0] FBUF_FILL_MAX = FBUF_CNT_W'(FBUF_DEPTH - 2);

    // ------------------------------
    // Fetch buffer payload
    typedef struct packed {
        logic [15:0] data;                             // Halfword of instruction
        logic        err;                              // Bus error on its word
    } fetch_hw_t;

    typedef struct packed {
        logic [1:0]      cnt;                          // Halfwords pushed, 0..2
        fetch_hw_t [1:0] hw;                           // hw[0] is the lower address
    } fetch_push_t;

    // ------------------------------
    // Instruction memory bus
    typedef struct packed {
        logic            req;                          // Request, held until gnt
        logic [XLEN-1:0] addr;                         // Word address
    } imem_req_t;

    typedef struct packed {
        logic            gnt;                          // Request accepted
        logic            err;                          // Response error
        logic [XLEN-1:0] rdata;                        // Read data, same cycle as gnt
    } imem_rsp_t;

    // Control flow change, valid/ack
    typedef struct packed {
        logic            valid;                        // Redirect wanted
        logic [XLEN-1:0] target;                       // New PC, halfword aligned
    } cf_req_t;

    // Issue port toward decode
    typedef struct packed {
        logic            valid;                        // Instruction present
        logic [31:0]     instr;                        // Upper half zero if 16-bit
        logic [XLEN-1:0] pc;                           // Address of instruction
        logic            i16bit;                       // Compressed encoding
        logic            ferr;                         // Fetch error on any part
    } issue_t;

endpackage
`default_nettype wire
